/* bench/cpu_stim.txt */
// group instruction load_data overflow kind(0 none 1 store 2 load) address data
// group 1 alu, 2 immediate and shift, 3 overflow, 4 load round trip
1 45E00100 00000000 0 0 000 00000000
1 44112345 00000000 0 0 000 00000000
1 44280F0F 00000000 0 0 000 00000000
1 40308800 00000000 0 0 000 00000000
1 383F000A 00000000 0 1 100 FFF93254
1 40408801 00000000 0 0 000 00000000
1 384F000A 00000000 0 1 100 00091436
1 40508802 00000000 0 0 000 00000000
1 385F000A 00000000 0 1 100 00000305
1 40608804 00000000 0 0 000 00000000
1 386F000A 00000000 0 1 100 FFF92F4F
1 40708803 00000000 0 0 000 00000000
1 387F000A 00000000 0 1 100 FFF92C4A
2 5080FFFB 00000000 0 0 000 00000000
2 388F000A 00000000 0 1 100 00012340
2 5890C800 00000000 0 0 000 00000000
2 389F000A 00000000 0 1 100 00016B45
2 56A17FFF 00000000 0 0 000 00000000
2 38AF000A 00000000 0 1 100 FFF870F0
2 40B09008 00000000 0 0 000 00000000
2 38BF000A 00000000 0 1 100 00123450
2 40C12009 00000000 0 0 000 00000000
2 38CF000A 00000000 0 1 100 00FFF80F
2 40D0B00B 00000000 0 0 000 00000000
2 38DF000A 00000000 0 1 100 34500012
3 44E7FFFF 00000000 0 0 000 00000000
3 40E73008 00000000 0 0 000 00000000
3 40F73800 00000000 1 0 000 00000000
3 41013801 00000000 1 0 000 00000000
3 4117BC02 00000000 0 0 000 00000000
3 390F000A 00000000 0 1 100 7FF81F0F
3 38FF000A 00000000 0 1 100 FFFFE000
4 45200010 00000000 0 0 000 00000000
4 393F4802 CAFE0000 0 2 110 00000000
4 394F4902 0BAD0001 0 2 120 00000000
4 395F4A02 13572468 0 2 140 00000000
4 396F4B02 8000FFFF 0 2 180 00000000
4 393F000A 00000000 0 1 100 CAFE0000
4 394F000A 00000000 0 1 100 0BAD0001
4 395F000A 00000000 0 1 100 13572468
4 396F000A 00000000 0 1 100 8000FFFF

/* filelist.f */
source/cpu_pkg.sv
source/alu.sv
source/regfile.sv
source/operand_mux.sv
source/controller.sv
source/cpu_top.sv
bench/clock_gen.sv
bench/cpu_assertions.sv
bench/tb_cpu.sv

/* run.sh */
#!/bin/sh
# build and run from the project root
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f filelist.f --top-module tb_cpu -o tb_cpu_sim &&
./obj_dir/tb_cpu_sim | tee /dev/stderr | grep -q "ALL CHECKS PASSED" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

/* bench/tb_cpu.sv */
module tb_cpu import cpu_pkg::*; ();

	localparam int NUM_RECS = 41;
	localparam int REC_WORDS = 7;

	// record fields
	localparam int F_ID = 0;
	localparam int F_INSTR = 1;
	localparam int F_LOAD = 2;
	localparam int F_OVF = 3;
	localparam int F_KIND = 4;
	localparam int F_ADDR = 5;
	localparam int F_DATA = 6;

	logic clk;
	logic rst_n;
	word_t instruction;
	word_t dm_out;
	logic alu_overflow;
	logic im_read;
	logic im_write;
	logic im_enable;
	pc_t pc;
	logic dm_read;
	logic dm_write;
	logic dm_enable;
	dm_addr_t dm_address;
	word_t dm_in;

	logic [31:0] stim_mem [0:NUM_RECS*REC_WORDS-1];

	int errors = 0;
	int test_errors = 0;
	int seq_errors = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int cycle = 0;
	bit timed_out = 0;

	clock_gen u_clock_gen (
		.clk   (clk),
		.rst_n (rst_n)
	);

	cpu_top dut0 (
		.clk          (clk),
		.rst_n        (rst_n),
		.instruction  (instruction),
		.alu_overflow (alu_overflow),
		.im_read      (im_read),
		.im_write     (im_write),
		.im_enable    (im_enable),
		.pc           (pc),
		.dm_read      (dm_read),
		.dm_write     (dm_write),
		.dm_enable    (dm_enable),
		.dm_address   (dm_address),
		.dm_in        (dm_in),
		.dm_out       (dm_out)
	);

	bind cpu_top cpu_assertions u_cpu_assertions (
		.clk       (clk),
		.rst_n     (rst_n),
		.im_write  (im_write),
		.dm_read   (dm_read),
		.dm_write  (dm_write),
		.dm_enable (dm_enable),
		.pc        (pc)
	);

	function automatic logic [31:0] field(int rec, int f);
		return stim_mem[rec*REC_WORDS+f];
	endfunction

	function automatic string group_name(logic [31:0] id);
		case (id)
			32'd1:   return "register alu";
			32'd2:   return "immediate and shift";
			32'd3:   return "overflow";
			default: return "load round trip";
		endcase
	endfunction

	always @(posedge clk) begin
		cycle++;
	end

	// memory models answer 1 unit after the edge
	always @(posedge clk) begin
		#1;
		if (im_read && int'(pc) < NUM_RECS) begin
			instruction = field(int'(pc), F_INSTR);
		end else begin
			instruction = '0;
		end
		if (dm_read && int'(pc) < NUM_RECS) begin
			dm_out = field(int'(pc), F_LOAD);
		end else begin
			dm_out = '0;
		end
	end

	task automatic check_value(string what, logic [31:0] got, logic [31:0] exp);
		assert (got === exp) else begin
			$display("Fail at %0t: %s is %h, expected %h", $time, what, got, exp);
			errors++;
			test_errors++;
		end
	endtask

	task automatic check_bit(string what, logic got, logic exp);
		assert (got === exp) else begin
			$display("Fail at %0t: %s is %b, expected %b", $time, what, got, exp);
			errors++;
			test_errors++;
		end
	endtask

	task automatic report_test(string name);
		tests_run++;
		if (test_errors == 0) begin
			$display("test %s: passed", name);
		end else begin
			tests_failed++;
			$display("test %s: failed with %0d errors", name, test_errors);
		end
		test_errors = 0;
	endtask

	task automatic check_reset_outputs();
		check_bit("im_enable", im_enable, 1'b1);
		check_bit("im_read", im_read, 1'b1);
		check_bit("im_write", im_write, 1'b0);
		check_bit("dm_enable", dm_enable, 1'b0);
		check_bit("dm_read", dm_read, 1'b0);
		check_bit("dm_write", dm_write, 1'b0);
		check_value("pc", 32'(pc), 32'd0);
	endtask

	// polls on falling edges, the current one included
	task automatic wait_fetch(output bit seen);
		int n;
		seen = im_read;
		for (n = 0; n < 8 && !seen; n++) begin
			@(negedge clk);
			seen = im_read;
		end
	endtask

	initial begin
		int n;
		int last_fetch;
		bit seen;
		logic [31:0] kind;

		instruction = '0;
		dm_out = '0;
		last_fetch = 0;
		$readmemh("bench/cpu_stim.txt", stim_mem);

		// reset and the first cycle after it
		@(negedge clk);
		for (n = 0; n < 10 && !rst_n; n++) begin
			check_reset_outputs();
			@(negedge clk);
		end
		if (!rst_n) begin
			$display("timeout: reset was never released");
			timed_out = 1;
		end else begin
			check_reset_outputs();
		end
		report_test("reset");

		for (int i = 0; i < NUM_RECS && !timed_out; i++) begin
			wait_fetch(seen);
			if (!seen) begin
				$display("timeout: instruction fetch for record %0d never came", i);
				timed_out = 1;
				break;
			end
			check_value("pc at fetch", 32'(pc), 32'(i));
			if (i > 0) begin
				assert (cycle - last_fetch == 4) else begin
					$display("Fail at %0t: fetches %0d cycles apart, expected 4",
						$time, cycle - last_fetch);
					errors++;
					seq_errors++;
				end
			end
			last_fetch = cycle;

			// fixed four-cycle timing puts writeback three cycles on
			repeat (3) @(negedge clk);
			check_bit("alu_overflow", alu_overflow, field(i, F_OVF) != 0);
			kind = field(i, F_KIND);
			if (kind == 32'd1) begin
				check_bit("dm_write", dm_write, 1'b1);
				check_bit("dm_read", dm_read, 1'b0);
				check_value("store dm_address", 32'(dm_address), field(i, F_ADDR));
				check_value("store dm_in", dm_in, field(i, F_DATA));
			end else if (kind == 32'd2) begin
				check_bit("dm_read", dm_read, 1'b1);
				check_bit("dm_write", dm_write, 1'b0);
				check_value("load dm_address", 32'(dm_address), field(i, F_ADDR));
			end else begin
				check_bit("dm_enable", dm_enable, 1'b0);
			end

			if (i == NUM_RECS - 1 || field(i + 1, F_ID) != field(i, F_ID)) begin
				report_test(group_name(field(i, F_ID)));
			end
		end

		test_errors = seq_errors;
		report_test("sequencing");

		$display("tests run: %0d, tests failed: %0d, check errors: %0d, assertion failures: %0d",
			tests_run, tests_failed, errors, dut0.u_cpu_assertions.failures);
		if (errors == 0 && !timed_out && dut0.u_cpu_assertions.failures == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

/* bench/cpu_assertions.sv */
module cpu_assertions import cpu_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic im_write,
	input logic dm_read,
	input logic dm_write,
	input logic dm_enable,
	input pc_t  pc
);

	// failed assertion count
	int failures = 0;

	rw_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
		!(dm_read && dm_write))
		else begin
			$error("data memory read and write strobes high together");
			failures++;
		end

	enable_match: assert property (@(posedge clk) disable iff (!rst_n)
		dm_enable == (dm_read || dm_write))
		else begin
			$error("dm_enable does not match the read and write strobes");
			failures++;
		end

	no_im_write: assert property (@(posedge clk) disable iff (!rst_n)
		!im_write)
		else begin
			$error("instruction memory write strobe went high");
			failures++;
		end

	// pc only steps forward by one
	pc_step: assert property (@(posedge clk) disable iff (!rst_n)
		(pc != $past(pc)) |-> (pc == $past(pc) + pc_t'(1)))
		else begin
			$error("pc changed by something other than one");
			failures++;
		end

endmodule

/* bench/clock_gen.sv */
module clock_gen (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever begin
			#5 clk = ~clk;
		end
	end

	// low for two rising edges, released just after the second
	initial begin
		rst_n = 1'b0;
		repeat (2) @(posedge clk);
		#1 rst_n = 1'b1;
	end

endmodule

/* source/cpu_top.sv */
module cpu_top import cpu_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  word_t    instruction,
	output logic     alu_overflow,

	output logic     im_read,
	output logic     im_write,
	output logic     im_enable,
	output pc_t      pc,

	output logic     dm_read,
	output logic     dm_write,
	output logic     dm_enable,
	output dm_addr_t dm_address,
	output word_t    dm_in,
	input  word_t    dm_out
);

	word_t ir;
	ctrl_t ctrl;
	logic  read_en;
	logic  exec_en;
	logic  wb_en;

	word_t rdata1;
	word_t rdata2;
	word_t src2;
	word_t wdata;
	word_t alu_result;

	assign dm_address = alu_result[11:0];
	assign dm_in      = rdata2;

	controller u_controller (
		.clk         (clk),
		.rst_n       (rst_n),
		.instruction (instruction),
		.ir          (ir),
		.ctrl        (ctrl),
		.read_en     (read_en),
		.exec_en     (exec_en),
		.wb_en       (wb_en),
		.pc          (pc),
		.im_enable   (im_enable),
		.im_read     (im_read),
		.im_write    (im_write),
		.dm_enable   (dm_enable),
		.dm_read     (dm_read),
		.dm_write    (dm_write)
	);

	// port 2 reads rb in decode and rt in execute
	regfile u_regfile (
		.clk      (clk),
		.rst_n    (rst_n),
		.read_en  (read_en),
		.write_en (wb_en & ctrl.reg_we),
		.raddr1   (ir[19:15]),
		.raddr2   (exec_en ? ir[24:20] : ir[14:10]),
		.waddr    (ir[24:20]),
		.wdata    (wdata),
		.rdata1   (rdata1),
		.rdata2   (rdata2)
	);

	alu u_alu (
		.clk      (clk),
		.rst_n    (rst_n),
		.exec_en  (exec_en),
		.alu_op   (ctrl.alu_op),
		.src1     (rdata1),
		.src2     (src2),
		.shamt    (ir[14:10]),
		.result   (alu_result),
		.overflow (alu_overflow)
	);

	operand_mux u_operand_mux (
		.ctrl       (ctrl),
		.ir         (ir),
		.rdata2     (rdata2),
		.alu_result (alu_result),
		.mem_rdata  (dm_out),
		.src2       (src2),
		.wdata      (wdata)
	);

endmodule

/* source/controller.sv */
module controller import cpu_pkg::*; (
	input  logic  clk,
	input  logic  rst_n,
	input  word_t instruction,
	output word_t ir,
	output ctrl_t ctrl,
	output logic  read_en,
	output logic  exec_en,
	output logic  wb_en,
	output pc_t   pc,
	output logic  im_enable,
	output logic  im_read,
	output logic  im_write,
	output logic  dm_enable,
	output logic  dm_read,
	output logic  dm_write
);

	typedef enum logic [1:0] {
		S_FETCH,
		S_DECODE,
		S_EXEC,
		S_WB
	} state_t;

	state_t state;
	state_t state_next;

	logic [5:0] opcode;
	logic [4:0] sub_alu;
	logic [7:0] sub_ls;
	logic       is_lw;
	logic       is_sw;

	assign opcode  = ir[30:25];
	assign sub_alu = ir[4:0];
	assign sub_ls  = ir[7:0];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= S_FETCH;
			ir    <= '0;
			pc    <= '0;
		end else begin
			state <= state_next;
			if (state == S_FETCH) begin
				ir <= instruction;
			end
			if (state == S_WB) begin
				pc <= pc + pc_t'(1);
			end
		end
	end

	always_comb begin
		case (state)
			S_FETCH:  state_next = S_DECODE;
			S_DECODE: state_next = S_EXEC;
			S_EXEC:   state_next = S_WB;
			default:  state_next = S_FETCH;
		endcase
	end

	// decode from the instruction register
	always_comb begin
		ctrl          = '0;
		ctrl.alu_op   = ALU_ADD;
		ctrl.src2_sel = SRC2_RB;
		is_lw         = 1'b0;
		is_sw         = 1'b0;
		case (opcode)
			OP_ALU: begin
				ctrl.reg_we = 1'b1;
				case (sub_alu)
					SUB_ADD: ctrl.alu_op = ALU_ADD;
					SUB_SUB: ctrl.alu_op = ALU_SUB;
					SUB_AND: ctrl.alu_op = ALU_AND;
					SUB_OR:  ctrl.alu_op = ALU_OR;
					SUB_XOR: ctrl.alu_op = ALU_XOR;
					SUB_SLLI: begin
						ctrl.alu_op   = ALU_SLL;
						ctrl.src2_sel = SRC2_IMM5;
					end
					SUB_SRLI: begin
						ctrl.alu_op   = ALU_SRL;
						ctrl.src2_sel = SRC2_IMM5;
					end
					SUB_ROTRI: begin
						ctrl.alu_op   = ALU_ROTR;
						ctrl.src2_sel = SRC2_IMM5;
					end
					default: ctrl.reg_we = 1'b0;
				endcase
			end
			OP_ADDI: begin
				ctrl.src2_sel   = SRC2_IMM;
				ctrl.imm_signed = 1'b1;
				ctrl.reg_we     = 1'b1;
			end
			OP_ORI: begin
				ctrl.alu_op   = ALU_OR;
				ctrl.src2_sel = SRC2_IMM;
				ctrl.reg_we   = 1'b1;
			end
			OP_XORI: begin
				ctrl.alu_op   = ALU_XOR;
				ctrl.src2_sel = SRC2_IMM;
				ctrl.reg_we   = 1'b1;
			end
			OP_MOVI: begin
				// or keeps the overflow flag clear
				ctrl.alu_op     = ALU_OR;
				ctrl.src2_sel   = SRC2_IMM;
				ctrl.imm_signed = 1'b1;
				ctrl.imm_wide   = 1'b1;
				ctrl.reg_we     = 1'b1;
			end
			OP_LS: begin
				ctrl.src2_sel = SRC2_RB_SV;
				case (sub_ls)
					LS_LW: begin
						ctrl.wb_from_mem = 1'b1;
						ctrl.reg_we      = 1'b1;
						is_lw            = 1'b1;
					end
					LS_SW:   is_sw = 1'b1;
					default: ;
				endcase
			end
			default: ;
		endcase
	end

	assign im_enable = (state == S_FETCH);
	assign im_read   = (state == S_FETCH);
	assign im_write  = 1'b0;

	// stores read rt again in execute, after rb is consumed
	assign read_en = (state == S_DECODE) || ((state == S_EXEC) && is_sw);
	assign exec_en = (state == S_EXEC);
	assign wb_en   = (state == S_WB);

	assign dm_read   = wb_en && is_lw;
	assign dm_write  = wb_en && is_sw;
	assign dm_enable = dm_read || dm_write;

endmodule

/* source/operand_mux.sv */
module operand_mux import cpu_pkg::*; (
	input  ctrl_t ctrl,
	input  word_t ir,
	input  word_t rdata2,
	input  word_t alu_result,
	input  word_t mem_rdata,
	output word_t src2,
	output word_t wdata
);

	word_t imm5;
	word_t imm_ext;
	word_t rb_sv;
	logic  imm_sign;

	assign imm5 = {27'b0, ir[14:10]};

	// 15-bit or 20-bit field, sign taken from its top bit
	assign imm_sign = ctrl.imm_signed & (ctrl.imm_wide ? ir[19] : ir[14]);

	always_comb begin
		if (ctrl.imm_wide) begin
			imm_ext = {{12{imm_sign}}, ir[19:0]};
		end else begin
			imm_ext = {{17{imm_sign}}, ir[14:0]};
		end
	end

	// scaled index for register-offset addressing
	assign rb_sv = rdata2 << ir[9:8];

	always_comb begin
		case (ctrl.src2_sel)
			SRC2_RB:    src2 = rdata2;
			SRC2_RB_SV: src2 = rb_sv;
			SRC2_IMM5:  src2 = imm5;
			default:    src2 = imm_ext;
		endcase
	end

	// movi writes its immediate straight through
	always_comb begin
		if (ctrl.wb_from_mem) begin
			wdata = mem_rdata;
		end else if (ctrl.imm_wide) begin
			wdata = imm_ext;
		end else begin
			wdata = alu_result;
		end
	end

endmodule

/* source/regfile.sv */
module regfile import cpu_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  logic      read_en,
	input  logic      write_en,
	input  reg_addr_t raddr1,
	input  reg_addr_t raddr2,
	input  reg_addr_t waddr,
	input  word_t     wdata,
	output word_t     rdata1,
	output word_t     rdata2
);

	word_t regs [NUM_REGS];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (write_en) begin
			regs[waddr] <= wdata;
		end
	end

	// both read ports latch together
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rdata1 <= '0;
			rdata2 <= '0;
		end else if (read_en) begin
			rdata1 <= regs[raddr1];
			rdata2 <= regs[raddr2];
		end
	end

endmodule

/* source/alu.sv */
module alu import cpu_pkg::*; (
	input  logic    clk,
	input  logic    rst_n,
	input  logic    exec_en,
	input  alu_op_t alu_op,
	input  word_t   src1,
	input  word_t   src2,
	input  logic [4:0] shamt,
	output word_t   result,
	output logic    overflow
);

	word_t sum;
	word_t diff;
	word_t rot;
	word_t next_result;
	logic  add_ovf;
	logic  sub_ovf;
	logic [63:0] rot_wide;

	assign sum  = src1 + src2;
	assign diff = src1 - src2;

	// rotate by shifting a doubled copy
	assign rot_wide = {src1, src1} >> shamt;
	assign rot      = rot_wide[31:0];

	assign add_ovf = (src1[31] == src2[31]) && (sum[31] != src1[31]);
	assign sub_ovf = (src1[31] != src2[31]) && (diff[31] != src1[31]);

	always_comb begin
		case (alu_op)
			ALU_ADD:  next_result = sum;
			ALU_SUB:  next_result = diff;
			ALU_AND:  next_result = src1 & src2;
			ALU_OR:   next_result = src1 | src2;
			ALU_XOR:  next_result = src1 ^ src2;
			ALU_SLL:  next_result = src1 << shamt;
			ALU_SRL:  next_result = src1 >> shamt;
			default:  next_result = rot;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			result   <= '0;
			overflow <= 1'b0;
		end else if (exec_en) begin
			result <= next_result;
			// only add and sub report signed overflow
			case (alu_op)
				ALU_ADD: overflow <= add_ovf;
				ALU_SUB: overflow <= sub_ovf;
				default: overflow <= 1'b0;
			endcase
		end
	end

endmodule

/* source/cpu_pkg.sv */
package cpu_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_addr_t;
	typedef logic [9:0]  pc_t;
	typedef logic [11:0] dm_addr_t;

	localparam int NUM_REGS = 32;

	// major opcodes, bits 30..25
	localparam logic [5:0] OP_LS   = 6'b011100;
	localparam logic [5:0] OP_ALU  = 6'b100000;
	localparam logic [5:0] OP_MOVI = 6'b100010;
	localparam logic [5:0] OP_ADDI = 6'b101000;
	localparam logic [5:0] OP_XORI = 6'b101011;
	localparam logic [5:0] OP_ORI  = 6'b101100;

	// register-form alu group, bits 4..0
	localparam logic [4:0] SUB_ADD   = 5'b00000;
	localparam logic [4:0] SUB_SUB   = 5'b00001;
	localparam logic [4:0] SUB_AND   = 5'b00010;
	localparam logic [4:0] SUB_XOR   = 5'b00011;
	localparam logic [4:0] SUB_OR    = 5'b00100;
	localparam logic [4:0] SUB_SLLI  = 5'b01000;
	localparam logic [4:0] SUB_SRLI  = 5'b01001;
	localparam logic [4:0] SUB_ROTRI = 5'b01011;

	// load/store group, bits 7..0
	localparam logic [7:0] LS_LW = 8'b00000010;
	localparam logic [7:0] LS_SW = 8'b00001010;

	typedef logic [2:0] alu_op_t;

	localparam alu_op_t ALU_ADD  = 3'd0;
	localparam alu_op_t ALU_SUB  = 3'd1;
	localparam alu_op_t ALU_AND  = 3'd2;
	localparam alu_op_t ALU_OR   = 3'd3;
	localparam alu_op_t ALU_XOR  = 3'd4;
	localparam alu_op_t ALU_SLL  = 3'd5;
	localparam alu_op_t ALU_SRL  = 3'd6;
	localparam alu_op_t ALU_ROTR = 3'd7;

	typedef logic [1:0] src2_sel_t;

	localparam src2_sel_t SRC2_RB    = 2'd0;
	localparam src2_sel_t SRC2_RB_SV = 2'd1;
	localparam src2_sel_t SRC2_IMM5  = 2'd2;
	localparam src2_sel_t SRC2_IMM   = 2'd3;

	// decoded controls, held for the whole instruction
	typedef struct packed {
		alu_op_t   alu_op;
		src2_sel_t src2_sel;
		logic      imm_signed;
		logic      imm_wide;
		logic      wb_from_mem;
		logic      reg_we;
	} ctrl_t;

endpackage
